/* include/lerp_consts.svh */
// -------------------------------------------------------------------------
// stage count equals the rate width; work width is data width + rate width
// -------------------------------------------------------------------------
`ifndef LERP_CONSTS_SVH
`define LERP_CONSTS_SVH

// interpolation rate bits, one pipeline stage per bit
`define LERP_RATE_WIDTH 4

// components per pixel
`define LERP_COMPONENTS 3

// signed width of one component
`define LERP_DATA_WIDTH 8

// each bisection doubles the scale, so four extra bits
`define LERP_WORK_WIDTH 12

// half of 2**rate width, added before the final shift
`define LERP_ROUND_OFFSET 8

`endif

/* hdl/lerp_pkg.sv */
// -------------------------------------------------------------------------
// shared types; components are signed and the tag is opaque sideband
// -------------------------------------------------------------------------
`include "lerp_consts.svh"

package lerp_pkg;

    // single components
    typedef logic signed [`LERP_DATA_WIDTH-1:0] comp_t;
    typedef logic signed [`LERP_WORK_WIDTH-1:0] wide_comp_t;

    // -------------------------------------------------------------------------
    // pixels
    // -------------------------------------------------------------------------

    // input and output pixel of 24 bits
    typedef comp_t [`LERP_COMPONENTS-1:0] pixel_t;

    // pixel at working width of 36 bits
    typedef wide_comp_t [`LERP_COMPONENTS-1:0] wide_pixel_t;

    // -------------------------------------------------------------------------
    // control
    // -------------------------------------------------------------------------

    typedef logic [`LERP_RATE_WIDTH-1:0] rate_t;

    // passed through untouched
    typedef logic [3:0] tag_t;

endpackage

/* hdl/lerp_stage.sv */
// -------------------------------------------------------------------------
// one bisection step that consumes the rate MSB and doubles the scale
// -------------------------------------------------------------------------
`include "lerp_consts.svh"

module lerp_stage
    import lerp_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cke,

    input  logic        in_valid,
    input  rate_t       in_rate,
    input  tag_t        in_tag,
    input  wide_pixel_t in_lo,
    input  wide_pixel_t in_hi,

    output logic        out_valid,
    output rate_t       out_rate,
    output tag_t        out_tag,
    output wide_pixel_t out_lo,
    output wide_pixel_t out_hi
);

    wide_pixel_t pivot;

    // rate bit picks which end the midpoint is taken against
    always_comb begin
        for (int i = 0; i < `LERP_COMPONENTS; i++) begin
            pivot[i] = in_rate[`LERP_RATE_WIDTH-1] ? in_hi[i] : in_lo[i];
        end
    end

    // -------------------------------------------------------------------------
    // registers
    // -------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (cke) begin
            out_valid <= in_valid;
        end
    end

    // lo+pivot and hi+pivot is the kept half, doubled
    always_ff @(posedge clk) begin
        if (cke) begin
            out_rate <= in_rate << 1;
            out_tag  <= in_tag;
            for (int i = 0; i < `LERP_COMPONENTS; i++) begin
                out_lo[i] <= in_lo[i] + pivot[i];
                out_hi[i] <= in_hi[i] + pivot[i];
            end
        end
    end

endmodule

/* hdl/lerp_pipeline.sv */
// -------------------------------------------------------------------------
// latency is one advancing cycle per rate bit; lo leaves scaled by 2**rate
// -------------------------------------------------------------------------
`include "lerp_consts.svh"

module lerp_pipeline
    import lerp_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cke,

    input  logic        in_valid,
    input  rate_t       in_rate,
    input  tag_t        in_tag,
    input  pixel_t      in_data0,
    input  pixel_t      in_data1,

    output logic        out_valid,
    output tag_t        out_tag,
    output wide_pixel_t out_lo
);

    localparam int STAGES = `LERP_RATE_WIDTH;

    // index k feeds stage k and index STAGES holds the final result
    logic        valid [0:STAGES];
    rate_t       rate  [0:STAGES];
    tag_t        tag   [0:STAGES];
    wide_pixel_t lo    [0:STAGES];
    wide_pixel_t hi    [0:STAGES];

    // -------------------------------------------------------------------------
    // sign extension to working width
    // -------------------------------------------------------------------------

    assign valid[0] = in_valid;
    assign rate[0]  = in_rate;
    assign tag[0]   = in_tag;

    for (genvar c = 0; c < `LERP_COMPONENTS; c++) begin : g_extend
        assign lo[0][c] = {{`LERP_RATE_WIDTH{in_data0[c][`LERP_DATA_WIDTH-1]}}, in_data0[c]};
        assign hi[0][c] = {{`LERP_RATE_WIDTH{in_data1[c][`LERP_DATA_WIDTH-1]}}, in_data1[c]};
    end

    // -------------------------------------------------------------------------
    // bisection chain
    // -------------------------------------------------------------------------

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        lerp_stage lerp_stage_inst (
            .clk       (clk),
            .reset     (reset),
            .cke       (cke),
            .in_valid  (valid[k]),
            .in_rate   (rate[k]),
            .in_tag    (tag[k]),
            .in_lo     (lo[k]),
            .in_hi     (hi[k]),
            .out_valid (valid[k+1]),
            .out_rate  (rate[k+1]),
            .out_tag   (tag[k+1]),
            .out_lo    (lo[k+1]),
            .out_hi    (hi[k+1])
        );
    end

    // interval has closed on lo, so hi and the spent rate stay here
    assign out_valid = valid[STAGES];
    assign out_tag   = tag[STAGES];
    assign out_lo    = lo[STAGES];

endmodule

/* hdl/lerp_round.sv */
// -------------------------------------------------------------------------
// rounds half up toward +inf; the result always lies between the endpoints
// -------------------------------------------------------------------------
`include "lerp_consts.svh"

module lerp_round
    import lerp_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cke,

    input  logic        in_valid,
    input  tag_t        in_tag,
    input  wide_pixel_t in_lo,

    output logic        out_valid,
    output tag_t        out_tag,
    output pixel_t      out_data
);

    localparam wide_comp_t ROUND_OFFSET = `LERP_ROUND_OFFSET;

    wide_pixel_t sum;
    wide_pixel_t shifted;

    // floor((x + 8) / 16)
    always_comb begin
        for (int i = 0; i < `LERP_COMPONENTS; i++) begin
            sum[i]     = in_lo[i] + ROUND_OFFSET;
            shifted[i] = $signed(sum[i]) >>> `LERP_RATE_WIDTH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (cke) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            out_tag <= in_tag;
            for (int i = 0; i < `LERP_COMPONENTS; i++) begin
                out_data[i] <= shifted[i][`LERP_DATA_WIDTH-1:0];
            end
        end
    end

endmodule

/* hdl/lerp_top.sv */
// -------------------------------------------------------------------------
// fixed latency of 5 advancing cycles; cke low freezes every register
// -------------------------------------------------------------------------

module lerp_top
    import lerp_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   cke,

    input  logic   in_valid,
    input  rate_t  in_rate,
    input  tag_t   in_tag,
    input  pixel_t in_data0,
    input  pixel_t in_data1,

    output logic   out_valid,
    output tag_t   out_tag,
    output pixel_t out_data
);

    // pipeline to rounding stage
    logic        pipe_valid;
    tag_t        pipe_tag;
    wide_pixel_t pipe_lo;

    lerp_pipeline lerp_pipeline_inst (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (in_valid),
        .in_rate   (in_rate),
        .in_tag    (in_tag),
        .in_data0  (in_data0),
        .in_data1  (in_data1),
        .out_valid (pipe_valid),
        .out_tag   (pipe_tag),
        .out_lo    (pipe_lo)
    );

    lerp_round lerp_round_inst (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (pipe_valid),
        .in_tag    (pipe_tag),
        .in_lo     (pipe_lo),
        .out_valid (out_valid),
        .out_tag   (out_tag),
        .out_data  (out_data)
    );

endmodule

/* dv/lerp_tb.sv */
// -------------------------------------------------------------------------
// directed tests against a behavioral model; latency counted in cke cycles
// -------------------------------------------------------------------------
`include "lerp_consts.svh"

module lerp_tb
    import lerp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int LATENCY      = `LERP_RATE_WIDTH + 1;
    localparam int DRAIN_LIMIT  = 4 * LATENCY;
    localparam int STREAM_BEATS = 200;

    // upper bound on stimulus cycles where a stalled beat costs at most 7
    localparam int STIM_CYCLES = RESET_CYCLES + 32 + 9 + STREAM_BEATS + STREAM_BEATS * 7
                                 + 4 + 3 + 8 + 5 + 5 * (DRAIN_LIMIT + 2);
    localparam int WATCHDOG_NS = (STIM_CYCLES + 50) * CLK_PERIOD;

    typedef struct packed {
        tag_t   tag;
        pixel_t data;
        int     due;
    } expected_t;

    logic   clk;
    logic   reset;
    logic   cke;
    logic   in_valid;
    rate_t  in_rate;
    tag_t   in_tag;
    pixel_t in_data0;
    pixel_t in_data1;
    logic   out_valid;
    tag_t   out_tag;
    pixel_t out_data;

    integer    seed;
    expected_t expected [$];
    int        checks;
    int        monitor_errors;
    int        stim_errors;

    // monitor state
    int     adv_count;
    bit     prev_reset;
    bit     prev_cke;
    logic   prev_valid;
    tag_t   prev_tag;
    pixel_t prev_data;

    lerp_top lerp_top_inst (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in_valid  (in_valid),
        .in_rate   (in_rate),
        .in_tag    (in_tag),
        .in_data0  (in_data0),
        .in_data1  (in_data1),
        .out_valid (out_valid),
        .out_tag   (out_tag),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("** FAIL **");
        $finish;
    end

    // -------------------------------------------------------------------------
    // model and random helpers
    // -------------------------------------------------------------------------

    // floor((d0*(16-r) + d1*r + 8) / 16) per component
    function automatic pixel_t interp_model(input pixel_t d0, input pixel_t d1, input rate_t r);
        pixel_t res;
        int     acc;
        int     shifted;
        for (int i = 0; i < `LERP_COMPONENTS; i++) begin
            acc = int'(d0[i]) * ((1 << `LERP_RATE_WIDTH) - int'(r)) + int'(d1[i]) * int'(r);
            shifted = (acc + `LERP_ROUND_OFFSET) >>> `LERP_RATE_WIDTH;
            res[i] = shifted[`LERP_DATA_WIDTH-1:0];
        end
        return res;
    endfunction

    function automatic int pick_below(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    function automatic pixel_t any_pixel();
        logic [31:0] bits;
        bits = $random(seed);
        return bits[$bits(pixel_t)-1:0];
    endfunction

    function automatic logic [3:0] any_nibble();
        logic [31:0] bits;
        bits = $random(seed);
        return bits[3:0];
    endfunction

    // -------------------------------------------------------------------------
    // stimulus
    // -------------------------------------------------------------------------

    task automatic drive_beat(input logic valid, input logic enable, input rate_t rate,
                              input tag_t tag, input pixel_t d0, input pixel_t d1);
        @(posedge clk);
        cke      <= enable;
        in_valid <= valid;
        in_rate  <= rate;
        in_tag   <= tag;
        in_data0 <= d0;
        in_data1 <= d1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_beat(1'b0, 1'b1, '0, '0, '0, '0);
    endtask

    // two idles so the last beat is in the scoreboard before polling
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        idle_cycles(2);
        while (expected.size() != 0 && cycles < DRAIN_LIMIT) begin
            idle_cycles(1);
            cycles++;
        end
        assert (expected.size() == 0) else begin
            $display("%0d results still missing after %0d idle cycles at %0t",
                     expected.size(), cycles + 2, $time);
            stim_errors++;
        end
    endtask

    task automatic check_endpoints();
        pixel_t pix [4];
        pix[0] = {8'h7f, 8'h80, 8'h00};
        pix[1] = {8'h80, 8'h7f, 8'h01};
        pix[2] = {8'hff, 8'h40, 8'hc0};
        pix[3] = {8'h80, 8'h80, 8'h7f};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                drive_beat(1'b1, 1'b1, 4'd0, any_nibble(), pix[i], pix[j]);
                drive_beat(1'b1, 1'b1, 4'd15, any_nibble(), pix[i], pix[j]);
            end
        end
        wait_drain();
    endtask

    // negative and mixed-sign ends at quarter and half rates
    task automatic rounding_cases();
        pixel_t lo_end [3];
        pixel_t hi_end [3];
        rate_t  rates  [3];
        lo_end[0] = {-8'sd3, -8'sd3, 8'sd3};
        hi_end[0] = {8'sd4, -8'sd4, -8'sd4};
        lo_end[1] = {-8'sd1, -8'sd1, -8'sd128};
        hi_end[1] = {8'sd0, -8'sd2, 8'sd127};
        lo_end[2] = {-8'sd7, 8'sd5, -8'sd100};
        hi_end[2] = {-8'sd8, -8'sd6, -8'sd99};
        rates[0]  = 4'd4;
        rates[1]  = 4'd8;
        rates[2]  = 4'd12;
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < 3; p++) begin
                drive_beat(1'b1, 1'b1, rates[r], any_nibble(), lo_end[p], hi_end[p]);
            end
        end
        wait_drain();
    endtask

    // stalled cycles carry random junk that must be ignored
    task automatic random_stream(input logic stall);
        int run;
        for (int n = 0; n < STREAM_BEATS; n++) begin
            if (stall && pick_below(100) < 20) begin
                run = 1 + pick_below(6);
                repeat (run) begin
                    drive_beat(pick_below(2) == 1, 1'b0, any_nibble(), any_nibble(),
                               any_pixel(), any_pixel());
                end
            end
            drive_beat(pick_below(100) < 70, 1'b1, any_nibble(), any_nibble(),
                       any_pixel(), any_pixel());
        end
        wait_drain();
    endtask

    task automatic reset_mid_stream();
        for (int n = 0; n < 4; n++) begin
            drive_beat(1'b1, 1'b1, any_nibble(), any_nibble(), any_pixel(), any_pixel());
        end
        for (int n = 0; n < 2; n++) begin
            drive_beat(1'b1, 1'b1, any_nibble(), any_nibble(), any_pixel(), any_pixel());
            reset <= 1'b1;
        end
        drive_beat(1'b0, 1'b1, '0, '0, '0, '0);
        reset <= 1'b0;
        idle_cycles(8);
        for (int n = 0; n < 5; n++) begin
            drive_beat(1'b1, 1'b1, any_nibble(), any_nibble(), any_pixel(), any_pixel());
        end
        wait_drain();
    endtask

    // -------------------------------------------------------------------------
    // monitor and scoreboard
    // -------------------------------------------------------------------------

    always @(posedge clk) begin
        expected_t item;
        if (reset) begin
            expected.delete();
        end else begin
            if (prev_reset) begin
                checks++;
                assert (!out_valid) else begin
                    $display("FAIL %0t: out_valid high on the first edge after reset", $time);
                    monitor_errors++;
                end
            end
            // previous edge had cke low, so nothing may have moved
            if (!prev_cke && !prev_reset) begin
                checks++;
                assert (out_valid === prev_valid && out_tag === prev_tag
                        && out_data === prev_data) else begin
                    $display("FAIL %0t: outputs changed while cke was low", $time);
                    monitor_errors++;
                end
            end
            if (cke && out_valid) begin
                assert (expected.size() != 0) else begin
                    $display("a result came out at %0t with no beat outstanding", $time);
                    monitor_errors++;
                end
                if (expected.size() != 0) begin
                    item = expected.pop_front();
                    checks++;
                    assert (item.due == adv_count) else begin
                        $display("FAIL %0t: result at advance %0d, due at advance %0d",
                                 $time, adv_count, item.due);
                        monitor_errors++;
                    end
                    assert (out_tag == item.tag) else begin
                        $display("FAIL %0t: tag %h, expected %h", $time, out_tag, item.tag);
                        monitor_errors++;
                    end
                    assert (out_data == item.data) else begin
                        $display("FAIL %0t: data %h, expected %h", $time, out_data, item.data);
                        monitor_errors++;
                    end
                end
            end else if (cke && expected.size() != 0) begin
                assert (expected[0].due != adv_count) else begin
                    $display("no result came out at %0t for the beat due at advance %0d",
                             $time, adv_count);
                    monitor_errors++;
                    item = expected.pop_front();
                end
            end
            if (cke && in_valid) begin
                item.tag  = in_tag;
                item.data = interp_model(in_data0, in_data1, in_rate);
                item.due  = adv_count + LATENCY;
                expected.push_back(item);
            end
        end
        if (cke) begin
            adv_count++;
        end
        prev_reset = reset;
        prev_cke   = cke;
        prev_valid = out_valid;
        prev_tag   = out_tag;
        prev_data  = out_data;
    end

    // -------------------------------------------------------------------------
    // test sequence
    // -------------------------------------------------------------------------

    initial begin
        int total;
        seed = 32'h1cc4;
        reset    <= 1'b1;
        cke      <= 1'b1;
        in_valid <= 1'b0;
        in_rate  <= '0;
        in_tag   <= '0;
        in_data0 <= '0;
        in_data1 <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        check_endpoints();
        rounding_cases();
        random_stream(1'b0);
        random_stream(1'b1);
        reset_mid_stream();

        assert (expected.size() == 0) else begin
            $display("%0d expected results were never seen", expected.size());
            stim_errors++;
        end
        total = monitor_errors + stim_errors;
        $display("checks %0d, monitor errors %0d, stimulus errors %0d, total errors %0d",
                 checks, monitor_errors, stim_errors, total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hdl/lerp_pkg.sv
hdl/lerp_stage.sv
hdl/lerp_pipeline.sv
hdl/lerp_round.sv
hdl/lerp_top.sv
dv/lerp_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=lerp_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module lerp_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
